/* design/rob_pkg.sv */
package rob_pkg;

  // reorder buffer size, indices wrap modulo this
  localparam int ROB_DEPTH = 32;

  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
  typedef logic [4:0]                   arch_reg_t;
  typedef logic [5:0]                   phys_reg_t;

  // destination carried by every in-flight item
  typedef struct packed {
    arch_reg_t dest;
    phys_reg_t phys;
    rob_idx_t  rob;
  } result_tag_t;

  // span is tail minus rollback index, modulo ROB_DEPTH
  typedef struct packed {
    logic     active;
    rob_idx_t rollback_idx;
    rob_idx_t span;
  } squash_window_t;

  // true when idx sits at or after rollback_idx and not past the tail
  function automatic logic in_squash_window(squash_window_t window, rob_idx_t idx);
    rob_idx_t distance;
    // index width wraps the subtraction around the ring
    distance = idx - window.rollback_idx;
    return window.active && (distance <= window.span);
  endfunction

endpackage

/* design/mult_pkg.sv */
package mult_pkg;

  localparam int DATA_WIDTH    = 64;
  localparam int LITERAL_WIDTH = 8;

  typedef logic [DATA_WIDTH-1:0] word_t;

  // issue request from the reservation station
  typedef struct packed {
    word_t                    opa;
    word_t                    opb;
    logic [LITERAL_WIDTH-1:0] literal;
    logic                     opb_is_imm;
    rob_pkg::result_tag_t     tag;
  } mult_req_t;

  // item moving between pipeline stages
  typedef struct packed {
    // running sum of partial products
    word_t                product;
    // multiplier, consumed one chunk per stage from the low end
    word_t                mplier;
    // multiplicand, shifted up to match the next chunk
    word_t                mcand;
    rob_pkg::result_tag_t tag;
  } stage_data_t;

  // finished product handed to the result bus
  typedef struct packed {
    word_t                product;
    rob_pkg::result_tag_t tag;
  } mult_result_t;

endpackage

/* design/mult_issue.sv */
`timescale 1ns/10ps

module mult_issue (
  input  logic                    issue_valid,
  input  mult_pkg::mult_req_t     issue,
  input  logic                    rollback_valid,
  input  rob_pkg::rob_idx_t       rollback_idx,
  input  rob_pkg::rob_idx_t       rob_tail,
  output logic                    first_valid,
  output mult_pkg::stage_data_t   first_data,
  output rob_pkg::squash_window_t window
);

  localparam int PAD_WIDTH = mult_pkg::DATA_WIDTH - mult_pkg::LITERAL_WIDTH;

  mult_pkg::word_t opb_value;

  // operand b is the register or the zero-extended literal
  always_comb begin
    if (issue.opb_is_imm) begin
      opb_value = {{PAD_WIDTH{1'b0}}, issue.literal};
    end else begin
      opb_value = issue.opb;
    end
  end

  // first stage item, product starts from zero
  always_comb begin
    first_data.product = '0;
    first_data.mplier  = issue.opa;
    first_data.mcand   = opb_value;
    first_data.tag     = issue.tag;
  end

  // no back-pressure, so the issue strobe goes straight in
  assign first_valid = issue_valid;

  // squash window shared by every stage and by writeback
  always_comb begin
    window.active       = rollback_valid;
    window.rollback_idx = rollback_idx;
    // distance from the rollback point to the tail, wraps with the ring
    window.span         = rob_tail - rollback_idx;
  end

endmodule

/* design/mult_stage.sv */
`timescale 1ns/10ps

module mult_stage #(
  parameter int NUM_STAGES = 4
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    in_valid,
  input  mult_pkg::stage_data_t   in_data,
  input  rob_pkg::squash_window_t window,
  output logic                    out_valid,
  output mult_pkg::stage_data_t   out_data
);

  // bits of the multiplier consumed per stage
  localparam int CHUNK = mult_pkg::DATA_WIDTH / NUM_STAGES;

  logic [CHUNK-1:0]      mplier_chunk;
  mult_pkg::word_t       chunk_ext;
  mult_pkg::word_t       partial_product;
  mult_pkg::stage_data_t next_data;
  logic                  squashed;

  assign mplier_chunk = in_data.mplier[CHUNK-1:0];
  assign chunk_ext    = {{(mult_pkg::DATA_WIDTH-CHUNK){1'b0}}, mplier_chunk};

  // only the low 64 bits of the partial product matter
  assign partial_product = chunk_ext * in_data.mcand;

  always_comb begin
    next_data.product = in_data.product + partial_product;
    // line the next chunk up with a shifted multiplicand
    next_data.mplier  = in_data.mplier >> CHUNK;
    next_data.mcand   = in_data.mcand << CHUNK;
    next_data.tag     = in_data.tag;
  end

  // incoming item younger than the branch gets dropped
  assign squashed = rob_pkg::in_squash_window(window, in_data.tag.rob);

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid && !squashed;
    end
  end

  // payload only moves with a live item
  always_ff @(posedge clock) begin
    if (in_valid) begin
      out_data <= next_data;
    end
  end

endmodule

/* design/mult_writeback.sv */
`timescale 1ns/10ps

module mult_writeback (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    last_valid,
  input  mult_pkg::stage_data_t   last_data,
  input  rob_pkg::squash_window_t window,
  output logic                    result_valid,
  output mult_pkg::mult_result_t  result
);

  logic                  squashed;
  mult_pkg::mult_result_t next_result;

  // rollback can still catch the item leaving the last stage
  assign squashed = rob_pkg::in_squash_window(window, last_data.tag.rob);

  // mplier and mcand are spent by now, keep product and tag
  always_comb begin
    next_result.product = last_data.product;
    next_result.tag     = last_data.tag;
  end

  // one-cycle strobe, no back-pressure from the result bus
  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= last_valid && !squashed;
    end
  end

  always_ff @(posedge clock) begin
    if (last_valid) begin
      result <= next_result;
    end
  end

endmodule

/* design/mult_unit.sv */
`timescale 1ns/10ps

module mult_unit #(
  parameter int NUM_STAGES = 4
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   issue_valid,
  input  mult_pkg::mult_req_t    issue,
  input  logic                   rollback_valid,
  input  rob_pkg::rob_idx_t      rollback_idx,
  input  rob_pkg::rob_idx_t      rob_tail,
  output logic                   result_valid,
  output mult_pkg::mult_result_t result
);

  // slot 0 comes from issue, slot NUM_STAGES feeds writeback
  logic                  stage_valid [NUM_STAGES+1];
  mult_pkg::stage_data_t stage_data  [NUM_STAGES+1];

  rob_pkg::squash_window_t window;

  mult_issue u_issue (
    .issue_valid    (issue_valid),
    .issue          (issue),
    .rollback_valid (rollback_valid),
    .rollback_idx   (rollback_idx),
    .rob_tail       (rob_tail),
    .first_valid    (stage_valid[0]),
    .first_data     (stage_data[0]),
    .window         (window)
  );

  // one partial-product stage per multiplier chunk
  for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
    mult_stage #(
      .NUM_STAGES (NUM_STAGES)
    ) u_stage (
      .clock     (clock),
      .reset     (reset),
      .in_valid  (stage_valid[k]),
      .in_data   (stage_data[k]),
      .window    (window),
      .out_valid (stage_valid[k+1]),
      .out_data  (stage_data[k+1])
    );
  end

  mult_writeback u_writeback (
    .clock        (clock),
    .reset        (reset),
    .last_valid   (stage_valid[NUM_STAGES]),
    .last_data    (stage_data[NUM_STAGES]),
    .window       (window),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

/* tests/mult_unit_checker.sv */
`timescale 1ns/10ps

module mult_unit_checker #(
  parameter int NUM_STAGES = 4
) (
  input logic clock,
  input logic reset,
  input logic issue_valid,
  input logic result_valid
);

  // the edge after any reset cycle leaves the strobe low
  reset_clears_result: assert property (
    @(posedge clock) reset |=> !result_valid
  ) else $error("result_valid high in the cycle after reset");

  // every result traces back to an issue one pipeline depth plus writeback ago
  result_follows_issue: assert property (
    @(posedge clock) disable iff (reset)
    result_valid |-> $past(issue_valid, NUM_STAGES + 1)
  ) else $error("result_valid without an issue %0d cycles earlier", NUM_STAGES + 1);

endmodule

bind mult_unit mult_unit_checker #(
  .NUM_STAGES (NUM_STAGES)
) u_checker (
  .clock        (clock),
  .reset        (reset),
  .issue_valid  (issue_valid),
  .result_valid (result_valid)
);

/* tests/mult_unit_tb.sv */
`timescale 1ns/10ps

module mult_unit_tb;

  localparam int NUM_STAGES   = 4;
  // issue edge to the edge where the result is sampled
  localparam int LATENCY      = NUM_STAGES + 1;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_RANDOM   = 20;

  // one row is applied per clock
  typedef struct packed {
    logic                 issue_valid;
    mult_pkg::mult_req_t  req;
    logic                 rollback_valid;
    rob_pkg::rob_idx_t    rollback_idx;
    rob_pkg::rob_idx_t    rob_tail;
    mult_pkg::word_t      expected;
    logic                 squash;
  } row_t;

  typedef struct packed {
    mult_pkg::word_t      product;
    rob_pkg::result_tag_t tag;
    logic [31:0]          due;
  } expect_t;

  logic                   clock = 1'b0;
  logic                   reset;
  logic                   issue_valid;
  mult_pkg::mult_req_t    issue;
  logic                   rollback_valid;
  rob_pkg::rob_idx_t      rollback_idx;
  rob_pkg::rob_idx_t      rob_tail;
  logic                   result_valid;
  mult_pkg::mult_result_t result;

  row_t    table_rows [$];
  expect_t expect_q [$];
  int      seed            = 92;
  int      value_errors    = 0;
  int      protocol_errors = 0;
  int      cycle_count     = 0;
  int      cycle_limit     = 1000;

  mult_unit #(
    .NUM_STAGES (NUM_STAGES)
  ) uut (
    .clock          (clock),
    .reset          (reset),
    .issue_valid    (issue_valid),
    .issue          (issue),
    .rollback_valid (rollback_valid),
    .rollback_idx   (rollback_idx),
    .rob_tail       (rob_tail),
    .result_valid   (result_valid),
    .result         (result)
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic add_idle();
    row_t row;
    row = '0;
    table_rows.push_back(row);
  endtask

  task automatic add_multiply(input mult_pkg::word_t a, input mult_pkg::word_t b,
                              input logic [mult_pkg::LITERAL_WIDTH-1:0] literal,
                              input logic opb_is_imm, input rob_pkg::rob_idx_t rob,
                              input logic squash);
    row_t            row;
    mult_pkg::word_t b_used;
    row = '0;
    // zero-extended literal replaces the register value
    b_used = opb_is_imm ? mult_pkg::word_t'(literal) : b;
    row.issue_valid    = 1'b1;
    row.req.opa        = a;
    row.req.opb        = b;
    row.req.literal    = literal;
    row.req.opb_is_imm = opb_is_imm;
    row.req.tag.dest   = 5'(table_rows.size());
    row.req.tag.phys   = 6'(table_rows.size() + 9);
    row.req.tag.rob    = rob;
    // low 64 bits of the full product
    row.expected       = a * b_used;
    row.squash         = squash;
    table_rows.push_back(row);
  endtask

  task automatic add_tagged(input rob_pkg::rob_idx_t rob, input logic squash);
    add_multiply(64'h0000_1111_2222_0000 | mult_pkg::word_t'(rob), 64'h0000_0000_0003_0007,
                 8'h00, 1'b0, rob, squash);
  endtask

  // rollback goes on the most recent row
  task automatic attach_rollback(input rob_pkg::rob_idx_t rb, input rob_pkg::rob_idx_t tail);
    row_t row;
    row = table_rows.pop_back();
    row.rollback_valid = 1'b1;
    row.rollback_idx   = rb;
    row.rob_tail       = tail;
    table_rows.push_back(row);
  endtask

  task automatic build_table();
    mult_pkg::word_t a;
    mult_pkg::word_t b;
    repeat (2) add_idle();
    // register operands, corner values back to back
    add_multiply(64'h0, 64'h1234_5678_9abc_def0, 8'h00, 1'b0, 5'd0, 1'b0);
    add_multiply('1, '1, 8'h00, 1'b0, 5'd1, 1'b0);
    add_multiply(64'h1_0000_0000, 64'h8000_0000, 8'h00, 1'b0, 5'd2, 1'b0);
    add_multiply('1, 64'd3, 8'h00, 1'b0, 5'd3, 1'b0);
    add_multiply(64'h0000_0001_0000_0001, 64'h0000_0001_0000_0001, 8'h00, 1'b0, 5'd4, 1'b0);
    add_multiply(64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210, 8'h00, 1'b0, 5'd5, 1'b0);
    // literal operand, register b carries junk
    add_multiply(64'h0123_4567_89ab_cdef, 64'hdead_beef_dead_beef, 8'hff, 1'b1, 5'd6, 1'b0);
    add_multiply('1, 64'd5, 8'h80, 1'b1, 5'd7, 1'b0);
    add_multiply(64'd7, 64'd9, 8'h00, 1'b1, 5'd8, 1'b0);
    repeat (LATENCY) add_idle();
    // window 12..15, all five items still in flight at the rollback edge
    add_tagged(5'd10, 1'b0);
    add_tagged(5'd13, 1'b1);
    add_tagged(5'd16, 1'b0);
    add_tagged(5'd12, 1'b1);
    add_tagged(5'd15, 1'b1);
    attach_rollback(5'd12, 5'd15);
    // rob 12 reused right after the rollback
    add_tagged(5'd12, 1'b0);
    repeat (NUM_STAGES) add_idle();
    // rob 30 is already on the result bus when the rollback lands
    add_tagged(5'd30, 1'b0);
    // wrapping window 30..1, rob 1 sits in writeback
    add_tagged(5'd1, 1'b1);
    add_tagged(5'd29, 1'b0);
    add_tagged(5'd31, 1'b1);
    add_tagged(5'd2, 1'b0);
    add_idle();
    attach_rollback(5'd30, 5'd1);
    repeat (LATENCY) add_idle();
    for (int n = 0; n < NUM_RANDOM; n++) begin
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      add_multiply(a, b, 8'h00, 1'b0, 5'(n + 3), 1'b0);
    end
  endtask

  task automatic drive_idle();
    issue_valid    = 1'b0;
    issue          = '0;
    rollback_valid = 1'b0;
    rollback_idx   = '0;
    rob_tail       = '0;
  endtask

  task automatic apply_row(input row_t row, input int slot);
    expect_t item;
    issue_valid    = row.issue_valid;
    issue          = row.req;
    rollback_valid = row.rollback_valid;
    rollback_idx   = row.rollback_idx;
    rob_tail       = row.rob_tail;
    // squashed items never reach the result bus
    if (row.issue_valid && !row.squash) begin
      item.product = row.expected;
      item.tag     = row.req.tag;
      item.due     = 32'(slot + LATENCY);
      expect_q.push_back(item);
    end
  endtask

  task automatic check_outputs(input int slot);
    expect_t item;
    if (result_valid) begin
      assert (expect_q.size() != 0) else begin
        $display("result_valid high at slot %0d with no result outstanding", slot);
        protocol_errors++;
      end
      if (expect_q.size() != 0) begin
        item = expect_q.pop_front();
        assert (item.due == 32'(slot)) else begin
          $display("result for rob %0d arrived at slot %0d instead of slot %0d",
                   item.tag.rob, slot, item.due);
          protocol_errors++;
        end
        assert (result.product == item.product) else begin
          $display("CHECK FAILED result.product = %h, expected %h",
                   result.product, item.product);
          value_errors++;
        end
        assert (result.tag == item.tag) else begin
          $display("CHECK FAILED result.tag = %h, expected %h", result.tag, item.tag);
          value_errors++;
        end
      end
    end else if (expect_q.size() != 0) begin
      assert (expect_q[0].due != 32'(slot)) else begin
        $display("no result at slot %0d for rob %0d", slot, expect_q[0].tag.rob);
        protocol_errors++;
        item = expect_q.pop_front();
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    drive_idle();
    build_table();
    cycle_limit = table_rows.size() + NUM_STAGES + 40;
    repeat (RESET_CYCLES) begin
      @(negedge clock);
      assert (result_valid == 1'b0) else begin
        $display("CHECK FAILED result_valid = %h, expected %h", result_valid, 1'b0);
        value_errors++;
      end
    end
    reset = 1'b0;
    // outputs are checked before the next row goes in
    for (int i = 0; i < table_rows.size() + LATENCY + 1; i++) begin
      @(negedge clock);
      check_outputs(i);
      if (i < table_rows.size()) begin
        apply_row(table_rows[i], i);
      end else begin
        drive_idle();
      end
    end
    assert (expect_q.size() == 0) else begin
      $display("%0d expected results never arrived", expect_q.size());
      protocol_errors++;
    end
    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
design/rob_pkg.sv
design/mult_pkg.sv
design/mult_issue.sv
design/mult_stage.sv
design/mult_writeback.sv
design/mult_unit.sv
tests/mult_unit_checker.sv
tests/mult_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the multiply unit testbench with Verilator
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module mult_unit_tb \
  -f build.f \
  -o mult_unit_sim

# keep running past assertion errors so the testbench reaches its report
./obj_dir/mult_unit_sim +verilator+error+limit+100 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
